/* mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// virtual address is {vpn, offset}
`define VA_WIDTH      14
`define VPN_WIDTH     6
`define OFFSET_WIDTH  8

// physical address is {ppn, offset}
`define PPN_WIDTH     2
`define PA_WIDTH      10

`define WORD_WIDTH    32

`define TLB_ENTRIES   4
`define AGE_WIDTH     2
`define AGE_MAX       3     // age given to a touched tlb entry

`define PT_ENTRIES    32    // pages at or above this always fault

// cache geometry
`define CACHE_SETS    2
`define CACHE_WAYS    2
`define BLOCK_WORDS   4

`define MEM_WORDS     256

`endif

/* mmu_pkg.sv */
`include "mmu_config.svh"

package mmu_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`VA_WIDTH-1:0]   vaddr_t;
    typedef logic [`PA_WIDTH-1:0]   paddr_t;

    typedef struct packed {
        logic   we;
        paddr_t addr;       // word address
        word_t  wdata;
    } mem_req_t;

    typedef struct packed {
        logic   we;
        logic   is_byte;
        vaddr_t vaddr;
        word_t  wdata;
    } cpu_req_t;

    // request after translation
    typedef struct packed {
        logic   we;
        logic   is_byte;
        logic   fault;
        logic   tlb_hit;
        paddr_t paddr;
        word_t  wdata;
    } phys_req_t;

    typedef struct packed {
        word_t rdata;
        logic  page_fault;
        logic  tlb_hit;
        logic  cache_hit;
    } resp_t;

    typedef struct packed {
        logic [`VPN_WIDTH-1:0] vpn;
        logic [`PPN_WIDTH-1:0] ppn;
        logic                  valid;
    } pt_write_t;

endpackage

/* page_table.sv */
`include "mmu_config.svh"

module page_table import mmu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  wr_valid,
    input  pt_write_t             wr,
    input  logic [`VPN_WIDTH-1:0] lookup_vpn,
    output logic [`PPN_WIDTH-1:0] lookup_ppn,
    output logic                  lookup_valid,
    output logic                  invalidate,
    output logic [`VPN_WIDTH-1:0] invalidate_vpn
);

    localparam int IDX_BITS = $clog2(`PT_ENTRIES);

    logic [`PT_ENTRIES-1:0] pte_valid;
    logic [`PPN_WIDTH-1:0]  pte_ppn [`PT_ENTRIES];
    logic                   wr_in_range;
    logic                   lookup_in_range;

    assign wr_in_range     = (wr.vpn < `PT_ENTRIES);
    assign lookup_in_range = (lookup_vpn < `PT_ENTRIES);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pte_valid <= '0;
        end else if (wr_valid && wr_in_range) begin
            pte_valid[wr.vpn[IDX_BITS-1:0]] <= wr.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_valid && wr_in_range) begin
            pte_ppn[wr.vpn[IDX_BITS-1:0]] <= wr.ppn;
        end
    end

    // combinational so a tlb miss resolves in the request cycle
    assign lookup_valid = lookup_in_range && pte_valid[lookup_vpn[IDX_BITS-1:0]];
    assign lookup_ppn   = pte_ppn[lookup_vpn[IDX_BITS-1:0]];

    // tlb drops its copy on the same edge that stores the new mapping
    assign invalidate     = wr_valid;
    assign invalidate_vpn = wr.vpn;

endmodule

/* tlb.sv */
`include "mmu_config.svh"

module tlb import mmu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  cpu_req_t              req,
    input  logic [`PPN_WIDTH-1:0] lookup_ppn,
    input  logic                  lookup_valid,
    input  logic                  invalidate,
    input  logic [`VPN_WIDTH-1:0] invalidate_vpn,
    output logic [`VPN_WIDTH-1:0] lookup_vpn,
    output logic                  phys_valid,
    output phys_req_t             phys
);

    localparam int IDX_BITS = $clog2(`TLB_ENTRIES);

    logic [`TLB_ENTRIES-1:0] ent_valid;
    logic [`VPN_WIDTH-1:0]   ent_tag [`TLB_ENTRIES];
    logic [`PPN_WIDTH-1:0]   ent_ppn [`TLB_ENTRIES];
    logic [`AGE_WIDTH-1:0]   ent_age [`TLB_ENTRIES];

    logic [`TLB_ENTRIES-1:0] match;
    logic                    hit;
    logic [IDX_BITS-1:0]     hit_idx;
    logic [IDX_BITS-1:0]     victim;
    logic                    victim_found;
    logic [IDX_BITS-1:0]     sel;           // entry touched by this request
    logic                    fault;
    logic                    fill;

    assign lookup_vpn = req.vaddr[`VA_WIDTH-1 -: `VPN_WIDTH];

    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
            match[i] = ent_valid[i] && (ent_tag[i] == lookup_vpn);
            if (match[i]) begin
                hit_idx = IDX_BITS'(i);
            end
        end
    end

    assign hit = |match;

    // first invalid entry, then first aged-out entry, then entry 0
    always_comb begin
        victim_found = 1'b0;
        victim       = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!victim_found && !ent_valid[i]) begin
                victim       = IDX_BITS'(i);
                victim_found = 1'b1;
            end
        end
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!victim_found && ent_age[i] == '0) begin
                victim       = IDX_BITS'(i);
                victim_found = 1'b1;
            end
        end
    end

    assign fault = !hit && !lookup_valid;
    assign fill  = req_valid && !hit && lookup_valid;
    assign sel   = hit ? hit_idx : victim;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                ent_age[i] <= '0;
            end
        end else begin
            if (req_valid && !fault) begin
                for (int i = 0; i < `TLB_ENTRIES; i++) begin
                    if (IDX_BITS'(i) == sel) begin
                        ent_age[i] <= `AGE_WIDTH'(`AGE_MAX);
                    end else if (ent_age[i] != '0) begin
                        ent_age[i] <= ent_age[i] - 1'b1;
                    end
                end
            end
            if (fill) begin
                ent_valid[sel] <= 1'b1;
            end
            // a fill racing a remap of the same page is dropped too
            if (invalidate) begin
                for (int i = 0; i < `TLB_ENTRIES; i++) begin
                    if (ent_tag[i] == invalidate_vpn ||
                        (fill && IDX_BITS'(i) == sel && lookup_vpn == invalidate_vpn)) begin
                        ent_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            ent_tag[sel] <= lookup_vpn;
            ent_ppn[sel] <= lookup_ppn;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            phys_valid <= 1'b0;
        end else begin
            phys_valid <= req_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid) begin
            phys.we      <= req.we;
            phys.is_byte <= req.is_byte;
            phys.fault   <= fault;
            phys.tlb_hit <= hit;
            phys.paddr   <= {(hit ? ent_ppn[hit_idx] : lookup_ppn),
                             req.vaddr[`OFFSET_WIDTH-1:0]};
            phys.wdata   <= req.wdata;
        end
    end

    // fills only follow a miss and remaps only clear, so a page sits in one entry
    assert property (@(posedge clock) disable iff (!rst_n) $onehot0(match))
        else $error("tlb holds vpn %0d in more than one entry", lookup_vpn);

endmodule

/* cache_ctrl.sv */
`include "mmu_config.svh"

module cache_ctrl import mmu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      phys_valid,
    input  phys_req_t phys,
    input  word_t     mem_rdata,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    output logic      done,
    output resp_t     resp,
    output logic      busy
);

    localparam int BYTE_BITS = 2;
    localparam int WORD_BITS = $clog2(`BLOCK_WORDS);
    localparam int SET_BITS  = $clog2(`CACHE_SETS);
    localparam int WAY_BITS  = $clog2(`CACHE_WAYS);
    localparam int TAG_BITS  = `PA_WIDTH - SET_BITS - WORD_BITS - BYTE_BITS;

    typedef enum logic [1:0] {S_IDLE, S_WB, S_FILL, S_UPD} state_t;

    state_t               state;
    logic [WORD_BITS-1:0] cnt;      // block word on the memory bus
    phys_req_t            cur;      // request held across a miss
    logic [WAY_BITS-1:0]  vway;

    logic [`CACHE_WAYS-1:0] line_valid [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] line_dirty [`CACHE_SETS];
    logic [TAG_BITS-1:0]    line_tag   [`CACHE_SETS][`CACHE_WAYS];
    word_t                  line_data  [`CACHE_SETS][`CACHE_WAYS][`BLOCK_WORDS];
    logic [WAY_BITS-1:0]    lru        [`CACHE_SETS];  // least recently used way

    phys_req_t              acc;
    logic [BYTE_BITS-1:0]   a_byte;
    logic [WORD_BITS-1:0]   a_word;
    logic [SET_BITS-1:0]    a_set;
    logic [TAG_BITS-1:0]    a_tag;
    logic [`CACHE_WAYS-1:0] hit_vec;
    logic                   hit;
    logic [WAY_BITS-1:0]    hit_way;
    logic [WAY_BITS-1:0]    victim;
    logic [WAY_BITS-1:0]    a_way;
    word_t                  old_word;
    word_t                  new_word;
    word_t                  ld_data;

    // held request owns the address while a miss is serviced
    assign acc    = (state == S_IDLE) ? phys : cur;
    assign a_byte = acc.paddr[BYTE_BITS-1:0];
    assign a_word = acc.paddr[BYTE_BITS +: WORD_BITS];
    assign a_set  = acc.paddr[BYTE_BITS+WORD_BITS +: SET_BITS];
    assign a_tag  = acc.paddr[`PA_WIDTH-1 -: TAG_BITS];

    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            hit_vec[w] = line_valid[a_set][w] && (line_tag[a_set][w] == a_tag);
            if (hit_vec[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // lowest invalid way if there is one
    always_comb begin
        victim = lru[a_set];
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (!line_valid[a_set][w]) begin
                victim = WAY_BITS'(w);
            end
        end
    end

    assign a_way = (state == S_IDLE) ? hit_way : vway;

    // last refill word is still on the bus in the update cycle
    assign old_word = (state == S_UPD && a_word == WORD_BITS'(`BLOCK_WORDS-1)) ?
                      mem_rdata : line_data[a_set][a_way][a_word];

    always_comb begin
        new_word = acc.wdata;
        ld_data  = old_word;
        if (acc.is_byte) begin
            new_word                  = old_word;
            new_word[8*a_byte +: 8]   = acc.wdata[7:0];    // little-endian lane
            ld_data                   = word_t'(old_word[8*a_byte +: 8]);
        end
    end

    assign mem_req_valid = (state == S_WB) || (state == S_FILL);
    assign busy          = phys_valid || (state != S_IDLE);

    always_comb begin
        mem_req.we    = (state == S_WB);
        mem_req.wdata = line_data[a_set][vway][cnt];
        if (state == S_WB) begin
            mem_req.addr = paddr_t'({line_tag[a_set][vway], a_set, cnt});
        end else begin
            mem_req.addr = paddr_t'({a_tag, a_set, cnt});
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                line_valid[s] <= '0;
                line_dirty[s] <= '0;
                lru[s]        <= '0;
            end
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (phys_valid) begin
                        if (phys.fault) begin
                            done <= 1'b1;
                        end else if (hit) begin
                            done       <= 1'b1;
                            lru[a_set] <= ~a_way;
                            if (phys.we) begin
                                line_dirty[a_set][a_way] <= 1'b1;
                            end
                        end else begin
                            cnt   <= '0;
                            state <= line_dirty[a_set][victim] ? S_WB : S_FILL;
                        end
                    end
                end
                S_WB: begin
                    cnt <= cnt + 1'b1;     // wraps to 0 for the refill
                    if (cnt == WORD_BITS'(`BLOCK_WORDS-1)) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == WORD_BITS'(`BLOCK_WORDS-1)) begin
                        state <= S_UPD;
                    end
                end
                default: begin
                    line_valid[a_set][vway] <= 1'b1;
                    line_dirty[a_set][vway] <= cur.we;
                    lru[a_set]              <= ~vway;
                    done                    <= 1'b1;
                    state                   <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            S_IDLE: begin
                if (phys_valid) begin
                    cur             <= phys;
                    vway            <= victim;
                    resp.rdata      <= phys.fault ? '0 : ld_data;
                    resp.page_fault <= phys.fault;
                    resp.tlb_hit    <= phys.tlb_hit;
                    resp.cache_hit  <= hit && !phys.fault;
                    if (!phys.fault && hit && phys.we) begin
                        line_data[a_set][a_way][a_word] <= new_word;
                    end
                end
            end
            S_FILL: begin
                if (cnt != '0) begin
                    line_data[a_set][vway][WORD_BITS'(cnt - 1'b1)] <= mem_rdata;
                end
            end
            S_UPD: begin
                line_tag[a_set][vway]                <= a_tag;
                line_data[a_set][vway][`BLOCK_WORDS-1] <= mem_rdata;
                if (cur.we) begin
                    line_data[a_set][vway][a_word] <= new_word;   // overrides the refill word
                end
                resp.rdata      <= ld_data;
                resp.page_fault <= 1'b0;
                resp.tlb_hit    <= cur.tlb_hit;
                resp.cache_hit  <= 1'b0;
            end
            default: begin
            end
        endcase
    end

    // outside waits on busy and the tlb adds one cycle, so requests never overlap a miss
    assert property (@(posedge clock) disable iff (!rst_n) phys_valid |-> state == S_IDLE)
        else $error("cache request arrived while a miss was in progress");

endmodule

/* main_memory.sv */
`include "mmu_config.svh"

module main_memory import mmu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    output word_t    rdata
);

    localparam int IDX_BITS = $clog2(`MEM_WORDS);

    word_t               mem [`MEM_WORDS];
    logic [IDX_BITS-1:0] idx;

    assign idx = req.addr[IDX_BITS-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (req_valid && req.we) begin
            mem[idx] <= req.wdata;
        end
    end

    // read data shows up the cycle after the request
    always_ff @(posedge clock) begin
        if (req_valid && !req.we) begin
            rdata <= mem[idx];
        end
    end

    // cache builds the word address from tag, set and word fields
    assert property (@(posedge clock) disable iff (!rst_n) req_valid |-> req.addr < `MEM_WORDS)
        else $error("memory word address %0d out of range", req.addr);

endmodule

/* mmu_top.sv */
`include "mmu_config.svh"

module mmu_top import mmu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      req_valid,
    input  cpu_req_t  req,
    input  logic      pt_wr_valid,
    input  pt_write_t pt_wr,
    output logic      done,
    output resp_t     resp,
    output logic      busy
);

    logic [`VPN_WIDTH-1:0] lookup_vpn;
    logic [`PPN_WIDTH-1:0] lookup_ppn;
    logic                  lookup_valid;
    logic                  invalidate;
    logic [`VPN_WIDTH-1:0] invalidate_vpn;
    logic                  phys_valid;
    phys_req_t             phys;
    logic                  mem_req_valid;
    mem_req_t              mem_req;
    word_t                 mem_rdata;

    page_table u_page_table (
        .clock          (clock),
        .rst_n          (rst_n),
        .wr_valid       (pt_wr_valid),
        .wr             (pt_wr),
        .lookup_vpn     (lookup_vpn),
        .lookup_ppn     (lookup_ppn),
        .lookup_valid   (lookup_valid),
        .invalidate     (invalidate),
        .invalidate_vpn (invalidate_vpn)
    );

    tlb u_tlb (
        .clock          (clock),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .lookup_ppn     (lookup_ppn),
        .lookup_valid   (lookup_valid),
        .invalidate     (invalidate),
        .invalidate_vpn (invalidate_vpn),
        .lookup_vpn     (lookup_vpn),
        .phys_valid     (phys_valid),
        .phys           (phys)
    );

    cache_ctrl u_cache_ctrl (
        .clock         (clock),
        .rst_n         (rst_n),
        .phys_valid    (phys_valid),
        .phys          (phys),
        .mem_rdata     (mem_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .done          (done),
        .resp          (resp),
        .busy          (busy)
    );

    main_memory u_main_memory (
        .clock     (clock),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .rdata     (mem_rdata)
    );

endmodule

/* tb_mmu.sv */
`include "mmu_config.svh"

module tb_mmu import mmu_pkg::*; ();

    localparam int NUM_REQS   = 300;
    localparam int WAIT_LIMIT = 100;    // cycles, covers a write-back plus refill easily
    localparam int PT_IDX     = $clog2(`PT_ENTRIES);

    logic      clock;
    logic      rst_n;
    logic      req_valid;
    cpu_req_t  req;
    logic      pt_wr_valid;
    pt_write_t pt_wr;
    logic      done;
    resp_t     resp;
    logic      busy;

    logic [15:0] lfsr_state;
    int          value_errors;
    int          timeout_errors;
    logic        stop_run;
    int          n_reqs;
    int          n_tlb_hits;
    int          n_cache_hits;
    int          n_faults;
    int          n_writebacks;

    // reference model
    logic                  pt_valid  [`PT_ENTRIES];
    logic [`PPN_WIDTH-1:0] pt_ppn    [`PT_ENTRIES];
    logic                  tlb_valid [`TLB_ENTRIES];
    logic [`VPN_WIDTH-1:0] tlb_tag   [`TLB_ENTRIES];
    logic [`PPN_WIDTH-1:0] tlb_ppn   [`TLB_ENTRIES];
    int                    tlb_age   [`TLB_ENTRIES];
    logic                  c_valid   [`CACHE_SETS][`CACHE_WAYS];
    logic                  c_dirty   [`CACHE_SETS][`CACHE_WAYS];
    int                    c_tag     [`CACHE_SETS][`CACHE_WAYS];
    int                    c_lru     [`CACHE_SETS];
    word_t                 mem_model [`MEM_WORDS];
    logic [`VPN_WIDTH-1:0] vpn_pool  [8];     // few pages so the tlb and cache both thrash

    mmu_top dut0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .pt_wr_valid (pt_wr_valid),
        .pt_wr       (pt_wr),
        .done        (done),
        .resp        (resp),
        .busy        (busy)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // galois lfsr, taps 16,14,13,11
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %0b got %0b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %0t done latency expected %0d got %0d", $time, exp, act);
            value_errors++;
        end
    endtask

    // translate and apply the aging rule; faults leave the tlb untouched
    task automatic model_tlb(input logic [`VPN_WIDTH-1:0] vpn, output logic hit,
                             output logic fault, output logic [`PPN_WIDTH-1:0] ppn);
        int sel;
        hit   = 1'b0;
        fault = 1'b0;
        ppn   = '0;
        sel   = -1;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (tlb_valid[i] && tlb_tag[i] == vpn) begin
                hit = 1'b1;
                sel = i;
                ppn = tlb_ppn[i];
            end
        end
        if (!hit) begin
            if (vpn < `PT_ENTRIES && pt_valid[vpn[PT_IDX-1:0]]) begin
                ppn = pt_ppn[vpn[PT_IDX-1:0]];
                for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
                    if (!tlb_valid[i]) sel = i;
                end
                if (sel < 0) begin
                    for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
                        if (tlb_age[i] == 0) sel = i;
                    end
                end
                if (sel < 0) sel = 0;
                tlb_valid[sel] = 1'b1;
                tlb_tag[sel]   = vpn;
                tlb_ppn[sel]   = ppn;
            end else begin
                fault = 1'b1;
            end
        end
        if (!fault) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (i == sel) tlb_age[i] = `AGE_MAX;
                else if (tlb_age[i] != 0) tlb_age[i]--;
            end
        end
    endtask

    // tag 5 bits, set 1 bit, word 2 bits, byte 2 bits
    task automatic model_cache(input paddr_t pa, input logic we, output logic hit);
        int set;
        int tag;
        int way;
        set = pa[4];
        tag = pa[9:5];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (c_valid[set][w] && c_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = c_lru[set];
            for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
                if (!c_valid[set][w]) way = w;
            end
            if (c_valid[set][way] && c_dirty[set][way]) n_writebacks++;
            c_valid[set][way] = 1'b1;
            c_tag[set][way]   = tag;
            c_dirty[set][way] = 1'b0;
        end
        if (we) c_dirty[set][way] = 1'b1;
        c_lru[set] = 1 - way;
    endtask

    task automatic write_pte(input logic [`VPN_WIDTH-1:0] vpn,
                             input logic [`PPN_WIDTH-1:0] ppn, input logic valid);
        pt_write_t w;
        w.vpn   = vpn;
        w.ppn   = ppn;
        w.valid = valid;
        if (vpn < `PT_ENTRIES) begin
            pt_valid[vpn[PT_IDX-1:0]] = valid;
            pt_ppn[vpn[PT_IDX-1:0]]   = ppn;
        end
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (tlb_tag[i] == vpn) tlb_valid[i] = 1'b0;   // ages stay as they are
        end
        @(posedge clock);
        pt_wr_valid <= 1'b1;
        pt_wr       <= w;
        @(posedge clock);
        pt_wr_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clock);
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (busy) begin
            $display("ERROR: DUT still busy after %0d cycles at time %0t", WAIT_LIMIT, $time);
            timeout_errors++;
            stop_run = 1'b1;
        end
    endtask

    task automatic run_request(input cpu_req_t r);
        logic [`VPN_WIDTH-1:0] vpn;
        logic [`PPN_WIDTH-1:0] ppn;
        logic                  exp_tlb_hit;
        logic                  exp_fault;
        logic                  exp_cache_hit;
        paddr_t                pa;
        int                    widx;
        int                    lane;
        int                    lat;
        word_t                 exp_rdata;

        vpn = r.vaddr[`VA_WIDTH-1 -: `VPN_WIDTH];
        model_tlb(vpn, exp_tlb_hit, exp_fault, ppn);
        pa            = {ppn, r.vaddr[`OFFSET_WIDTH-1:0]};
        widx          = pa[9:2];
        lane          = pa[1:0];
        exp_cache_hit = 1'b0;
        exp_rdata     = '0;
        if (!exp_fault) begin
            model_cache(pa, r.we, exp_cache_hit);
            if (r.is_byte) begin
                exp_rdata = word_t'(mem_model[widx][8*lane +: 8]);  // zero-extended lane
                if (r.we) mem_model[widx][8*lane +: 8] = r.wdata[7:0];
            end else begin
                exp_rdata = mem_model[widx];
                if (r.we) mem_model[widx] = r.wdata;
            end
        end
        n_reqs++;
        n_tlb_hits   += exp_tlb_hit;
        n_cache_hits += exp_cache_hit;
        n_faults     += exp_fault;

        wait_idle();
        if (stop_run) return;
        @(posedge clock);
        req_valid <= 1'b1;
        req       <= r;
        lat = 0;
        @(negedge clock);
        while (!done && lat < WAIT_LIMIT) begin
            @(posedge clock);
            req_valid <= 1'b0;
            @(negedge clock);
            lat++;
            if (!done) begin
                check_flag("busy", 1'b1, busy);    // request still in flight
            end
        end
        if (!done) begin
            $display("ERROR: no done pulse within %0d cycles of the request, time %0t",
                     WAIT_LIMIT, $time);
            timeout_errors++;
            stop_run = 1'b1;
            return;
        end
        check_flag("busy", 1'b0, busy);
        check_flag("resp.page_fault", exp_fault, resp.page_fault);
        check_flag("resp.tlb_hit", exp_tlb_hit, resp.tlb_hit);
        check_flag("resp.cache_hit", exp_cache_hit, resp.cache_hit);
        if (!exp_fault && !r.we) begin
            check_word("resp.rdata", exp_rdata, resp.rdata);
        end
        if (exp_fault || exp_cache_hit) begin
            check_latency(2, lat);
        end
    endtask

    initial begin
        cpu_req_t              r;
        logic [`VPN_WIDTH-1:0] vpn;
        logic [`PPN_WIDTH-1:0] ppn;
        logic                  valid;
        logic [2:0]            pick;
        logic [5:0]            low;

        lfsr_state     = 16'd75;
        value_errors   = 0;
        timeout_errors = 0;
        stop_run       = 1'b0;
        n_reqs         = 0;
        n_tlb_hits     = 0;
        n_cache_hits   = 0;
        n_faults       = 0;
        n_writebacks   = 0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        pt_wr_valid    = 1'b0;
        pt_wr          = '0;
        for (int i = 0; i < `PT_ENTRIES; i++) begin
            pt_valid[i] = 1'b0;
            pt_ppn[i]   = '0;
        end
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            tlb_valid[i] = 1'b0;
            tlb_tag[i]   = '0;
            tlb_ppn[i]   = '0;
            tlb_age[i]   = 0;
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            c_lru[s] = 0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                c_valid[s][w] = 1'b0;
                c_dirty[s][w] = 1'b0;
                c_tag[s][w]   = 0;
            end
        end
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_model[i] = '0;
        end
        // 9 stays unmapped, 40 is beyond the page table
        vpn_pool = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd5, 6'd6, 6'd9, 6'd40};

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        // map 20 of the first 24 pages, every fifth one left out
        for (int v = 0; v < 24; v++) begin
            ppn = rand_bits(2);
            write_pte(v, ppn, (v % 5) != 4);
        end
        ppn = rand_bits(2);
        write_pte(6'd40, ppn, 1'b1);    // ignored by the page table, still faults

        for (int i = 0; i < NUM_REQS && !stop_run; i++) begin
            if (rand_bits(4) == 0) begin
                pick  = rand_bits(3);
                ppn   = rand_bits(2);
                valid = (rand_bits(3) != 0);
                write_pte(vpn_pool[pick], ppn, valid);
            end
            r.we      = rand_bits(1);
            r.is_byte = rand_bits(1);
            pick      = rand_bits(3);
            low       = rand_bits(6);
            vpn       = vpn_pool[pick];
            r.vaddr   = {vpn, 2'b00, low};
            r.wdata   = rand_bits(32);
            run_request(r);
        end

        $display("requests %0d, tlb hits %0d, cache hits %0d, faults %0d, write-backs %0d",
                 n_reqs, n_tlb_hits, n_cache_hits, n_faults, n_writebacks);
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
mmu_pkg.sv
page_table.sv
tlb.sv
cache_ctrl.sv
main_memory.sv
mmu_top.sv
tb_mmu.sv
